// File: heapPkg.sv
// Heap package
// Widths, action codes, error codes and size table operations shared across the heap
package heapPkg;

  // ----------------------------------------------------------
  // Geometry
  localparam int addressBits = 2;                    // Bits in an array number
  localparam int indexBits   = 2;                    // Bits in an element index
  localparam int dataBits    = 12;                   // Element width
  localparam int arrayCount  = 2 ** addressBits;     // Number of arrays
  localparam int arrayLength = 2 ** indexBits;       // Elements per array
  localparam int sizeBits    = indexBits + 1;        // Holds 0 up to arrayLength
  localparam logic [sizeBits-1:0] fullSize = sizeBits'(arrayLength);

  // ----------------------------------------------------------
  // Action codes
  localparam int actionBits = 5;
  localparam logic [actionBits-1:0] actNone       = 5'd0;
  localparam logic [actionBits-1:0] actWrite      = 5'd1;
  localparam logic [actionBits-1:0] actRead       = 5'd2;
  localparam logic [actionBits-1:0] actSize       = 5'd3;
  localparam logic [actionBits-1:0] actInc        = 5'd4;
  localparam logic [actionBits-1:0] actDec        = 5'd5;
  localparam logic [actionBits-1:0] actPush       = 5'd6;
  localparam logic [actionBits-1:0] actPop        = 5'd7;
  localparam logic [actionBits-1:0] actAlloc      = 5'd8;
  localparam logic [actionBits-1:0] actFree       = 5'd9;
  localparam logic [actionBits-1:0] actAdd        = 5'd10;   // Returns new value
  localparam logic [actionBits-1:0] actAddAfter   = 5'd11;   // Returns old value
  localparam logic [actionBits-1:0] actSubtract   = 5'd12;
  localparam logic [actionBits-1:0] actSubAfter   = 5'd13;
  localparam logic [actionBits-1:0] actShiftLeft  = 5'd14;
  localparam logic [actionBits-1:0] actShiftRight = 5'd15;
  localparam logic [actionBits-1:0] actNotLogical = 5'd16;
  localparam logic [actionBits-1:0] actNot        = 5'd17;
  localparam logic [actionBits-1:0] actOr         = 5'd18;
  localparam logic [actionBits-1:0] actXor        = 5'd19;
  localparam logic [actionBits-1:0] actAnd        = 5'd20;   // Last valid code

  // ----------------------------------------------------------
  // Error codes
  localparam int errorBits = 3;
  localparam logic [errorBits-1:0] errNone         = 3'd0;
  localparam logic [errorBits-1:0] errNotAllocated = 3'd1;   // Also double free
  localparam logic [errorBits-1:0] errOutOfBounds  = 3'd2;
  localparam logic [errorBits-1:0] errFull         = 3'd3;
  localparam logic [errorBits-1:0] errEmpty        = 3'd4;
  localparam logic [errorBits-1:0] errOutOfMemory  = 3'd5;

  // Size table updates
  localparam int sizeOpBits = 3;
  localparam logic [sizeOpBits-1:0] sizeNone  = 3'd0;
  localparam logic [sizeOpBits-1:0] sizeWrite = 3'd1;        // Extend to cover index
  localparam logic [sizeOpBits-1:0] sizeInc   = 3'd2;
  localparam logic [sizeOpBits-1:0] sizeDec   = 3'd3;
  localparam logic [sizeOpBits-1:0] sizePush  = 3'd4;
  localparam logic [sizeOpBits-1:0] sizePop   = 3'd5;
  localparam logic [sizeOpBits-1:0] sizeClear = 3'd6;        // Fresh allocation

endpackage

// File: elementAlu.sv
// Element ALU
// Arithmetic, shift and logic on one element, results wrap at dataBits
`timescale 1ns/100ps

module elementAlu (
  input  logic [heapPkg::actionBits-1:0]  storeOp,
  input  logic [heapPkg::dataBits-1:0]    oldValue,
  input  logic [heapPkg::dataBits-1:0]    dataIn,
  output logic [heapPkg::dataBits-1:0]    newValue
);

  always_comb begin
    newValue = dataIn;                                  // Write and Push pass through
    case (storeOp)
      heapPkg::actAdd, heapPkg::actAddAfter:      newValue = oldValue + dataIn;
      heapPkg::actSubtract, heapPkg::actSubAfter: newValue = oldValue - dataIn;
      heapPkg::actShiftLeft:  newValue = oldValue << dataIn;
      heapPkg::actShiftRight: newValue = oldValue >> dataIn;
      heapPkg::actNotLogical: begin
        newValue    = '0;
        newValue[0] = oldValue == '0;                   // 1 or 0
      end
      heapPkg::actNot: newValue = ~oldValue;
      heapPkg::actOr:  newValue = oldValue | dataIn;
      heapPkg::actXor: newValue = oldValue ^ dataIn;
      heapPkg::actAnd: newValue = oldValue & dataIn;
      default:         newValue = dataIn;
    endcase
  end

endmodule

// File: elementStore.sv
// Element store
// Array element memory with a read-modify-write path through the ALU
`timescale 1ns/100ps

module elementStore (
  input  logic                             clock,
  input  logic                             storeWrite,
  input  logic [heapPkg::actionBits-1:0]   storeOp,
  input  logic [heapPkg::addressBits-1:0]  array,
  input  logic [heapPkg::indexBits-1:0]    elementIndex,
  input  logic [heapPkg::dataBits-1:0]     dataIn,
  output logic [heapPkg::dataBits-1:0]     oldValue,     // Element before the edge
  output logic [heapPkg::dataBits-1:0]     newValue      // Value written back
);

  logic [heapPkg::dataBits-1:0]  memory [heapPkg::arrayCount][heapPkg::arrayLength];

  assign oldValue = memory[array][elementIndex];

  elementAlu elementAlu_inst (
    .storeOp, .oldValue, .dataIn,
    .newValue
  );

  always_ff @(posedge clock) begin
    if (storeWrite) begin
      memory[array][elementIndex] <= newValue;
    end
  end

endmodule

// File: arraySizeTable.sv
// Array size table
// Current size of every array with write-extend, inc, dec, push, pop and clear
`timescale 1ns/100ps

module arraySizeTable (
  input  logic                             clock,
  input  logic                             resetN,
  input  logic [heapPkg::sizeOpBits-1:0]   sizeOp,
  input  logic [heapPkg::addressBits-1:0]  sizeArray,
  input  logic [heapPkg::indexBits-1:0]    index,
  output logic [heapPkg::sizeBits-1:0]     currentSize
);

  logic [heapPkg::sizeBits-1:0]  sizes [heapPkg::arrayCount];
  logic [heapPkg::sizeBits-1:0]  wideIndex;

  assign wideIndex   = {1'b0, index};
  assign currentSize = sizes[sizeArray];              // State before the edge

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < heapPkg::arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      case (sizeOp)
        heapPkg::sizeWrite: begin
          if (wideIndex >= currentSize) sizes[sizeArray] <= wideIndex + 1'b1;   // Grow to cover
        end
        heapPkg::sizeInc, heapPkg::sizePush: sizes[sizeArray] <= currentSize + 1'b1;
        heapPkg::sizeDec, heapPkg::sizePop:  sizes[sizeArray] <= currentSize - 1'b1;
        heapPkg::sizeClear:                  sizes[sizeArray] <= '0;
        default: ;                                      // No update
      endcase
    end
  end

endmodule

// File: arrayAllocator.sv
// Array allocator
// Allocation bits, high-water counter and a LIFO of freed arrays
`timescale 1ns/100ps

module arrayAllocator (
  input  logic                             clock,
  input  logic                             resetN,
  input  logic                             allocStrobe,
  input  logic                             freeStrobe,
  input  logic [heapPkg::addressBits-1:0]  array,
  output logic                             allocated,     // For the requested array
  output logic                             canAllocate,
  output logic [heapPkg::addressBits-1:0]  nextArray      // Array the next Alloc hands out
);

  logic [heapPkg::arrayCount-1:0]   allocBits;
  logic [heapPkg::addressBits:0]    highWater;            // Fresh arrays handed out so far
  logic [heapPkg::addressBits:0]    stackTop;             // Freed entries on the stack
  logic [heapPkg::addressBits-1:0]  freedStack [heapPkg::arrayCount];
  logic [heapPkg::addressBits-1:0]  topIndex;
  logic                             stackEmpty;

  assign stackEmpty  = stackTop == '0;
  assign topIndex    = stackTop[heapPkg::addressBits-1:0] - 1'b1;   // Wraps right when full
  assign allocated   = allocBits[array];
  assign canAllocate = !stackEmpty || !highWater[heapPkg::addressBits];   // Top bit set when used up
  assign nextArray   = stackEmpty ? highWater[heapPkg::addressBits-1:0] : freedStack[topIndex];

  // ----------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocBits <= '0;
      highWater <= '0;
      stackTop  <= '0;
    end else if (allocStrobe) begin
      allocBits[nextArray] <= 1'b1;
      if (stackEmpty) begin
        highWater <= highWater + 1'b1;            // Fresh array
      end else begin
        stackTop <= stackTop - 1'b1;              // Reuse most recently freed
      end
    end else if (freeStrobe) begin
      allocBits[array] <= 1'b0;
      stackTop         <= stackTop + 1'b1;
    end
  end

  // Freed array numbers
  always_ff @(posedge clock) begin
    if (freeStrobe) begin
      freedStack[stackTop[heapPkg::addressBits-1:0]] <= array;
    end
  end

endmodule

// File: heapController.sv
// Heap controller
// Decodes actions, applies access rules, drives one-cycle strobes
// and registers dataOut and error
`timescale 1ns/100ps

module heapController (
  input  logic                             clock,
  input  logic                             resetN,
  input  logic [heapPkg::actionBits-1:0]   action,
  input  logic [heapPkg::addressBits-1:0]  array,
  input  logic [heapPkg::indexBits-1:0]    index,
  input  logic [heapPkg::dataBits-1:0]     dataIn,
  input  logic                             allocated,      // Requested array in use
  input  logic                             canAllocate,
  input  logic [heapPkg::addressBits-1:0]  nextArray,
  input  logic [heapPkg::sizeBits-1:0]     currentSize,
  input  logic [heapPkg::dataBits-1:0]     oldValue,
  input  logic [heapPkg::dataBits-1:0]     newValue,
  output logic                             allocStrobe,
  output logic                             freeStrobe,
  output logic [heapPkg::sizeOpBits-1:0]   sizeOp,
  output logic [heapPkg::addressBits-1:0]  sizeArray,
  output logic                             storeWrite,
  output logic [heapPkg::actionBits-1:0]   storeOp,
  output logic [heapPkg::indexBits-1:0]    elementIndex,
  output logic [heapPkg::dataBits-1:0]     dataOut,
  output logic [heapPkg::errorBits-1:0]    error
);

  logic                            known;          // Not idle and a valid code
  logic                            isArith;        // Add through And
  logic                            accepted;       // Known and no error
  logic                            updatesOut;
  logic [heapPkg::errorBits-1:0]   errorNext;
  logic [heapPkg::dataBits-1:0]    result;
  logic [heapPkg::sizeBits-1:0]    sizeLess;

  assign known    = action != heapPkg::actNone && action <= heapPkg::actAnd;
  assign isArith  = action >= heapPkg::actAdd && action <= heapPkg::actAnd;
  assign accepted = known && errorNext == heapPkg::errNone;
  assign sizeLess = currentSize - 1'b1;            // Top element for Pop

  // ----------------------------------------------------------
  // Access rules
  always_comb begin
    errorNext = heapPkg::errNone;
    if (action == heapPkg::actAlloc) begin
      if (!canAllocate) errorNext = heapPkg::errOutOfMemory;
    end else if (!allocated) begin
      errorNext = heapPkg::errNotAllocated;
    end else if ((action == heapPkg::actRead || isArith) && {1'b0, index} >= currentSize) begin
      errorNext = heapPkg::errOutOfBounds;
    end else if ((action == heapPkg::actInc || action == heapPkg::actPush)
                 && currentSize == heapPkg::fullSize) begin
      errorNext = heapPkg::errFull;
    end else if ((action == heapPkg::actDec || action == heapPkg::actPop)
                 && currentSize == '0) begin
      errorNext = heapPkg::errEmpty;
    end
  end

  // Strobes and element addressing
  assign allocStrobe = accepted && action == heapPkg::actAlloc;
  assign freeStrobe  = accepted && action == heapPkg::actFree;
  assign sizeArray   = action == heapPkg::actAlloc ? nextArray : array;   // Clear lands on new array
  assign storeWrite  = accepted && (action == heapPkg::actWrite || action == heapPkg::actPush
                                    || isArith);
  assign storeOp     = action;                     // ALU decodes the action itself

  always_comb begin
    case (action)
      heapPkg::actPush: elementIndex = currentSize[heapPkg::indexBits-1:0];
      heapPkg::actPop:  elementIndex = sizeLess[heapPkg::indexBits-1:0];
      default:          elementIndex = index;
    endcase
  end

  always_comb begin
    sizeOp = heapPkg::sizeNone;
    if (accepted) begin
      case (action)
        heapPkg::actWrite: sizeOp = heapPkg::sizeWrite;
        heapPkg::actInc:   sizeOp = heapPkg::sizeInc;
        heapPkg::actDec:   sizeOp = heapPkg::sizeDec;
        heapPkg::actPush:  sizeOp = heapPkg::sizePush;
        heapPkg::actPop:   sizeOp = heapPkg::sizePop;
        heapPkg::actAlloc: sizeOp = heapPkg::sizeClear;
        default:           sizeOp = heapPkg::sizeNone;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Result select
  always_comb begin
    result     = '0;
    updatesOut = 1'b1;
    case (action)
      heapPkg::actAlloc: result[heapPkg::addressBits-1:0] = nextArray;
      heapPkg::actWrite: result = dataIn;
      heapPkg::actSize:  result[heapPkg::sizeBits-1:0] = currentSize;
      heapPkg::actPop, heapPkg::actRead,
      heapPkg::actAddAfter, heapPkg::actSubAfter: result = oldValue;
      default: begin
        result     = newValue;                     // Remaining arithmetic
        updatesOut = isArith;                      // Inc, Dec, Push, Free hold out
      end
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      dataOut <= '0;
      error   <= heapPkg::errNone;
    end else if (known) begin
      error <= errorNext;
      if (accepted && updatesOut) dataOut <= result;   // Held on error
    end
  end

endmodule

// File: heapMemory.sv
// Heap memory top
// Fixed-size array heap with a single-cycle command port and registered result
`timescale 1ns/100ps

module heapMemory (
  input  logic                             clock,
  input  logic                             resetN,
  input  logic [heapPkg::actionBits-1:0]   action,     // Command, actNone is idle
  input  logic [heapPkg::addressBits-1:0]  array,      // Array number
  input  logic [heapPkg::indexBits-1:0]    index,      // Element index
  input  logic [heapPkg::dataBits-1:0]     dataIn,
  output logic [heapPkg::dataBits-1:0]     dataOut,    // Valid one cycle after the action
  output logic [heapPkg::errorBits-1:0]    error
);

  logic                             allocStrobe;
  logic                             freeStrobe;
  logic                             allocated;
  logic                             canAllocate;
  logic [heapPkg::addressBits-1:0]  nextArray;
  logic [heapPkg::sizeOpBits-1:0]   sizeOp;
  logic [heapPkg::addressBits-1:0]  sizeArray;
  logic [heapPkg::sizeBits-1:0]     currentSize;
  logic                             storeWrite;
  logic [heapPkg::actionBits-1:0]   storeOp;
  logic [heapPkg::indexBits-1:0]    elementIndex;
  logic [heapPkg::dataBits-1:0]     oldValue;
  logic [heapPkg::dataBits-1:0]     newValue;

  // ----------------------------------------------------------
  heapController heapController_inst (
    .clock, .resetN, .action, .array, .index, .dataIn,
    .allocated, .canAllocate, .nextArray, .currentSize, .oldValue, .newValue,
    .allocStrobe, .freeStrobe, .sizeOp, .sizeArray,
    .storeWrite, .storeOp, .elementIndex, .dataOut, .error
  );

  arrayAllocator arrayAllocator_inst (
    .clock, .resetN, .allocStrobe, .freeStrobe, .array,
    .allocated, .canAllocate, .nextArray
  );

  arraySizeTable arraySizeTable_inst (
    .clock, .resetN, .sizeOp, .sizeArray, .index,
    .currentSize
  );

  elementStore elementStore_inst (
    .clock, .storeWrite, .storeOp, .array, .elementIndex, .dataIn,
    .oldValue, .newValue
  );

endmodule

// File: heapModel.svh
// Heap reference model
// Tracks allocation, sizes, freed arrays and elements, and predicts error and dataOut
`ifndef heapModelSvh
`define heapModelSvh

  // ----------------------------------------------------------
  // Model state
  bit                               modelAlloc [heapPkg::arrayCount];
  logic [heapPkg::sizeBits-1:0]     modelSize  [heapPkg::arrayCount];
  logic [heapPkg::dataBits-1:0]     modelMem   [heapPkg::arrayCount][heapPkg::arrayLength];
  logic [heapPkg::addressBits-1:0]  modelFreed [$];        // Latest free at the back
  int unsigned                      modelHigh;             // Fresh arrays handed out
  logic [heapPkg::dataBits-1:0]     expOut;
  logic [heapPkg::errorBits-1:0]    expErr;

  function automatic void resetModel();
    for (int a = 0; a < heapPkg::arrayCount; a++) begin
      modelAlloc[a] = 1'b0;
      modelSize[a]  = '0;
    end
    modelFreed.delete();
    modelHigh = 0;
    expOut    = '0;
    expErr    = heapPkg::errNone;
  endfunction

  // One element operation, wraps at dataBits
  function automatic logic [heapPkg::dataBits-1:0] elementResult(
    input logic [heapPkg::actionBits-1:0] act,
    input logic [heapPkg::dataBits-1:0]   oldV,
    input logic [heapPkg::dataBits-1:0]   din
  );
    case (act)
      heapPkg::actAdd, heapPkg::actAddAfter:      return oldV + din;
      heapPkg::actSubtract, heapPkg::actSubAfter: return oldV - din;
      heapPkg::actShiftLeft:  return oldV << din;  // Zero once din reaches the width
      heapPkg::actShiftRight: return oldV >> din;
      heapPkg::actNotLogical: return {{(heapPkg::dataBits-1){1'b0}}, oldV == '0};
      heapPkg::actNot:        return ~oldV;
      heapPkg::actOr:         return oldV | din;
      heapPkg::actXor:        return oldV ^ din;
      heapPkg::actAnd:        return oldV & din;
      default:                return din;
    endcase
  endfunction

  // Applies one action to the model and sets the expected outputs
  function automatic void predictAction(
    input logic [heapPkg::actionBits-1:0]  act,
    input logic [heapPkg::addressBits-1:0] arr,
    input logic [heapPkg::indexBits-1:0]   idx,
    input logic [heapPkg::dataBits-1:0]    din
  );
    logic                             arith;
    logic [heapPkg::addressBits-1:0]  pick;
    logic [heapPkg::dataBits-1:0]     oldV;
    logic [heapPkg::dataBits-1:0]     newV;
    logic [heapPkg::errorBits-1:0]    err;
    if (act == heapPkg::actNone) return;                 // Idle holds both outputs
    arith = act >= heapPkg::actAdd && act <= heapPkg::actAnd;
    err   = heapPkg::errNone;
    if (act == heapPkg::actAlloc) begin
      if (modelFreed.size() == 0 && modelHigh == heapPkg::arrayCount) err = heapPkg::errOutOfMemory;
    end else if (!modelAlloc[arr]) begin
      err = heapPkg::errNotAllocated;                    // Covers double free
    end else if ((act == heapPkg::actRead || arith) && idx >= modelSize[arr]) begin
      err = heapPkg::errOutOfBounds;
    end else if ((act == heapPkg::actInc || act == heapPkg::actPush)
                 && modelSize[arr] == heapPkg::arrayLength) begin
      err = heapPkg::errFull;
    end else if ((act == heapPkg::actDec || act == heapPkg::actPop) && modelSize[arr] == '0) begin
      err = heapPkg::errEmpty;
    end
    expErr = err;
    if (err != heapPkg::errNone) return;                 // Output holds
    case (act)
      heapPkg::actAlloc: begin
        if (modelFreed.size() != 0) begin
          pick = modelFreed.pop_back();                  // LIFO reuse
        end else begin
          pick      = modelHigh[heapPkg::addressBits-1:0];
          modelHigh = modelHigh + 1;
        end
        modelAlloc[pick] = 1'b1;
        modelSize[pick]  = '0;
        expOut = {{(heapPkg::dataBits-heapPkg::addressBits){1'b0}}, pick};
      end
      heapPkg::actFree: begin
        modelFreed.push_back(arr);
        modelAlloc[arr] = 1'b0;
      end
      heapPkg::actWrite: begin
        modelMem[arr][idx] = din;
        if (idx >= modelSize[arr]) modelSize[arr] = idx + 1'b1;   // Grow to cover
        expOut = din;
      end
      heapPkg::actRead: expOut = modelMem[arr][idx];
      heapPkg::actSize: expOut = modelSize[arr];
      heapPkg::actInc:  modelSize[arr] = modelSize[arr] + 1'b1;
      heapPkg::actDec:  modelSize[arr] = modelSize[arr] - 1'b1;
      heapPkg::actPush: begin
        modelMem[arr][modelSize[arr][heapPkg::indexBits-1:0]] = din;
        modelSize[arr] = modelSize[arr] + 1'b1;
      end
      heapPkg::actPop: begin
        modelSize[arr] = modelSize[arr] - 1'b1;
        expOut = modelMem[arr][modelSize[arr][heapPkg::indexBits-1:0]];
      end
      default: begin
        oldV = modelMem[arr][idx];
        newV = elementResult(act, oldV, din);
        modelMem[arr][idx] = newV;
        // After variants hand back the value before the update
        expOut = (act == heapPkg::actAddAfter || act == heapPkg::actSubAfter) ? oldV : newV;
      end
    endcase
  endfunction

`endif

// File: heapMemoryTb.sv
// Heap memory testbench
// Directed and random actions checked against a reference model on every cycle
`timescale 1ns/100ps

module heapMemoryTb;

  // ----------------------------------------------------------
  localparam int resetCycles     = 16;
  localparam int rwRounds        = 24;                   // Write, read, size rounds
  localparam int randomActions   = 2000;
  localparam int directedActions = 19 + 5 + 16 + 8 + 3 * rwRounds + 15;
  localparam int cycleLimit      = directedActions + randomActions + resetCycles + 50;

  logic                             clock;
  logic                             resetN;
  logic [heapPkg::actionBits-1:0]   action;
  logic [heapPkg::addressBits-1:0]  array;
  logic [heapPkg::indexBits-1:0]    index;
  logic [heapPkg::dataBits-1:0]     dataIn;
  logic [heapPkg::dataBits-1:0]     dataOut;
  logic [heapPkg::errorBits-1:0]    error;

  int unsigned                      cycleCount = 0;
  int unsigned                      checkCount = 0;
  int unsigned                      errorFails = 0;
  int unsigned                      dataFails  = 0;
  int unsigned                      rnd;
  logic [heapPkg::actionBits-1:0]   lastAction;         // For error lines
  logic [heapPkg::actionBits-1:0]   act;
  logic [heapPkg::addressBits-1:0]  arr;
  logic [heapPkg::indexBits-1:0]    idx;
  logic [heapPkg::dataBits-1:0]     din;

  `include "heapModel.svh"

  heapMemory heapMemory_inst (
    .clock, .resetN, .action, .array, .index, .dataIn,
    .dataOut, .error
  );

  initial clock = 1'b0;
  always #4 clock = ~clock;                             // 8 ns period

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: run went past %0d cycles", cycleLimit);
      $display("Test failures found");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Result of the action driven one cycle earlier
  task automatic checkOutputs();
    checkCount++;
    assert (error === expErr) else begin
      errorFails++;
      $display("** Error: error = %h, expected %h, action %0d", error, expErr, lastAction);
    end
    assert (dataOut === expOut) else begin
      dataFails++;
      $display("** Error: dataOut = %h, expected %h, action %0d", dataOut, expOut, lastAction);
    end
  endtask

  task automatic runAction(
    input logic [heapPkg::actionBits-1:0]  a,
    input logic [heapPkg::addressBits-1:0] r,
    input logic [heapPkg::indexBits-1:0]   i,
    input logic [heapPkg::dataBits-1:0]    d
  );
    @(negedge clock);
    checkOutputs();
    action     = a;
    array      = r;
    index      = i;
    dataIn     = d;
    lastAction = a;
    predictAction(a, r, i, d);
  endtask

  task automatic randomOperands();
    rnd = $urandom;
    arr = rnd[heapPkg::addressBits-1:0];
    idx = rnd[4 +: heapPkg::indexBits];
    din = rnd[8 +: heapPkg::dataBits];
  endtask

  // ----------------------------------------------------------
  initial begin
    int a;
    int i;
    void'($urandom(32'hcd44));
    resetN     = 1'b0;
    action     = heapPkg::actNone;
    array      = '0;
    index      = '0;
    dataIn     = '0;
    lastAction = heapPkg::actNone;
    resetModel();
    repeat (resetCycles) @(negedge clock);
    resetN = 1'b1;

    // Nothing allocated yet, then allocate all and one more
    for (a = 1; a <= heapPkg::actAnd; a++) begin
      act = a[heapPkg::actionBits-1:0];
      randomOperands();
      if (act != heapPkg::actAlloc) runAction(act, arr, idx, din);
    end
    repeat (heapPkg::arrayCount + 1) runAction(heapPkg::actAlloc, '0, '0, '0);

    // Fill every element
    for (a = 0; a < heapPkg::arrayCount; a++) begin
      for (i = 0; i < heapPkg::arrayLength; i++) begin
        randomOperands();
        runAction(heapPkg::actWrite, a[heapPkg::addressBits-1:0], i[heapPkg::indexBits-1:0], din);
      end
    end

    // Free, double free, LIFO reuse
    runAction(heapPkg::actFree, 1, '0, '0);
    runAction(heapPkg::actFree, 2, '0, '0);
    runAction(heapPkg::actFree, 2, '0, '0);
    runAction(heapPkg::actAlloc, '0, '0, '0);
    runAction(heapPkg::actSize, 2, '0, '0);
    runAction(heapPkg::actAlloc, '0, '0, '0);
    runAction(heapPkg::actSize, 1, '0, '0);
    runAction(heapPkg::actAlloc, '0, '0, '0);

    // Write, bounds-checked read, size updates
    repeat (rwRounds) begin
      randomOperands();
      runAction(heapPkg::actWrite, arr, idx, din);
      rnd = $urandom;
      runAction(heapPkg::actRead, arr, rnd[heapPkg::indexBits-1:0], '0);
      act = rnd[3:2] == 2'd0 ? heapPkg::actSize
          : rnd[3:2] == 2'd1 ? heapPkg::actDec : heapPkg::actInc;
      runAction(act, arr, '0, '0);
    end

    // Stack use of array 3
    repeat (heapPkg::arrayLength + 1) runAction(heapPkg::actPop, 3, '0, '0);
    repeat (heapPkg::arrayLength + 1) begin
      randomOperands();
      runAction(heapPkg::actPush, 3, '0, din);
    end
    repeat (heapPkg::arrayLength + 1) runAction(heapPkg::actPop, 3, '0, '0);

    // Random mix of all actions with idle cycles between them
    repeat (randomActions) begin
      rnd = $urandom_range(heapPkg::actAnd, 0);
      act = rnd[heapPkg::actionBits-1:0];
      randomOperands();
      if (act == heapPkg::actShiftLeft || act == heapPkg::actShiftRight) begin
        din[heapPkg::dataBits-1:4] = '0;                // Shift amounts around the width
      end
      runAction(act, arr, idx, din);
    end

    @(negedge clock);
    checkOutputs();
    action = heapPkg::actNone;
    $display("Checks %0d, error port mismatches %0d, dataOut mismatches %0d",
             checkCount, errorFails, dataFails);
    if (errorFails == 0 && dataFails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: heapMemory.f
heapPkg.sv
elementAlu.sv
elementStore.sv
arraySizeTable.sv
arrayAllocator.sv
heapController.sv
heapMemory.sv
+incdir+.
heapMemoryTb.sv

// File: runSim.sh
#!/bin/sh
# Builds the heap testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module heapMemoryTb -f heapMemory.f -o heapSim \
  && ./obj_dir/heapSim > sim.log 2>&1 \
  || echo "Build or simulation ended with an error"

cat sim.log 2>/dev/null

grep -qx "All tests passed!" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
